//--- include/serial_eeprom_config.svh
`ifndef SERIAL_EEPROM_CONFIG_SVH
`define SERIAL_EEPROM_CONFIG_SVH

// eight blocks picked by the block field of the control byte
`define SE_BANK_COUNT 8

// bytes in one block
`define SE_BANK_DEPTH 256

// upper nibble of a valid control byte
`define SE_DEVICE_CODE 4'b1010

// flops on each bus line before edge detection
`define SE_SYNC_STAGES 2

`endif

//--- design/serial_eeprom_pkg.sv
package serial_eeprom_pkg;

    // one-cycle pulses from the bus detector, plus the sampled data level
    typedef struct packed {
        logic start;
        logic stop;
        logic clk_rise;
        logic clk_fall;
        logic data;
    } bus_events_t;

    // control byte as it arrives msb first
    typedef struct packed {
        logic [3:0] device_code;
        logic [2:0] block;
        logic       rw;
    } ctrl_byte_t;

    // received byte seen as control or as plain address/data
    typedef union packed {
        ctrl_byte_t ctrl;
        logic [7:0] raw;
    } rx_byte_u;

    // write strobe broadcast to all banks
    typedef struct packed {
        logic       en;
        logic [2:0] block;
        logic [7:0] addr;
        logic [7:0] data;
    } mem_write_t;

    // location of the current read
    typedef struct packed {
        logic [2:0] block;
        logic [7:0] addr;
    } mem_read_t;

endpackage

//--- design/bus_condition_detect.sv
`include "serial_eeprom_config.svh"

module bus_condition_detect (
    input  logic                           scl,
    input  logic                           rst_n,
    input  logic                           bus_clk,
    input  logic                           bus_data,
    output serial_eeprom_pkg::bus_events_t events
);

    logic [`SE_SYNC_STAGES-1:0] clk_sync;
    logic [`SE_SYNC_STAGES-1:0] data_sync;
    logic                       clk_prev;
    logic                       data_prev;
    logic                       clk_now;
    logic                       data_now;

    assign clk_now  = clk_sync[`SE_SYNC_STAGES-1];
    assign data_now = data_sync[`SE_SYNC_STAGES-1];

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // idle bus is high on both lines
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
            data_prev <= 1'b1;
            events    <= '0;
        end
        else
        begin
            clk_sync  <= {clk_sync[`SE_SYNC_STAGES-2:0], bus_clk};
            data_sync <= {data_sync[`SE_SYNC_STAGES-2:0], bus_data};
            clk_prev  <= clk_now;
            data_prev <= data_now;

            events.clk_rise <= clk_now & ~clk_prev;
            events.clk_fall <= ~clk_now & clk_prev;
            // data moving while the clock stays high
            events.start    <= clk_now & clk_prev & data_prev & ~data_now;
            events.stop     <= clk_now & clk_prev & ~data_prev & data_now;
            events.data     <= data_now;
        end
    end

endmodule

//--- design/transfer_sequencer.sv
`include "serial_eeprom_config.svh"

module transfer_sequencer (
    input  logic                          scl,
    input  logic                          rst_n,
    input  serial_eeprom_pkg::bus_events_t events,
    input  logic [7:0]                    read_byte,
    output serial_eeprom_pkg::mem_write_t mem_write,
    output serial_eeprom_pkg::mem_read_t  mem_read,
    output logic                          bus_data_low
);

    import serial_eeprom_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CTRL,
        ST_ADDR,
        ST_DATA,
        ST_RD_CTRL,
        ST_RD_OUT,
        ST_WAIT_STOP
    } state_t;

    state_t     state;
    logic [3:0] bit_cnt;
    rx_byte_u   rx;
    logic [7:0] tx_shift;
    logic       receiving;
    logic       byte_ok;
    logic       ack_start;
    logic       ack_done;

    assign receiving = (state == ST_CTRL) || (state == ST_ADDR) ||
                       (state == ST_DATA) || (state == ST_RD_CTRL);

    // fall after the eighth bit, then fall after the ack bit
    assign ack_start = receiving && events.clk_fall && (bit_cnt == 4'd8);
    assign ack_done  = receiving && events.clk_fall && (bit_cnt == 4'd9);

    // only write control opens a transfer and only read control follows a repeated start
    always_comb
    begin
        case (state)
            ST_CTRL:
                byte_ok = (rx.ctrl.device_code == `SE_DEVICE_CODE) && !rx.ctrl.rw;
            ST_RD_CTRL:
                byte_ok = (rx.ctrl.device_code == `SE_DEVICE_CODE) && rx.ctrl.rw;
            default:
                byte_ok = 1'b1;
        endcase
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= ST_IDLE;
            bit_cnt      <= '0;
            bus_data_low <= 1'b0;
            mem_write    <= '0;
            mem_read     <= '0;
        end
        else
        begin
            mem_write.en <= 1'b0;

            if (events.stop)
            begin
                state        <= ST_IDLE;
                bit_cnt      <= '0;
                bus_data_low <= 1'b0;
            end
            else if (events.start)
            begin
                // start right after the address byte is the random read turnaround
                state        <= (state == ST_DATA) ? ST_RD_CTRL : ST_CTRL;
                bit_cnt      <= '0;
                bus_data_low <= 1'b0;
            end
            else if (receiving)
            begin
                if (events.clk_rise && bit_cnt != 4'd9)
                    bit_cnt <= bit_cnt + 4'd1;

                if (ack_start)
                begin
                    if (byte_ok)
                    begin
                        bus_data_low <= 1'b1;
                        case (state)
                            ST_CTRL:    mem_read.block <= rx.ctrl.block;
                            ST_RD_CTRL: mem_read.block <= rx.ctrl.block;
                            ST_ADDR:    mem_read.addr  <= rx.raw;
                            default:    ;
                        endcase
                    end
                    else
                    begin
                        // no ack so the line stays high
                        state   <= ST_IDLE;
                        bit_cnt <= '0;
                    end
                end
                else if (ack_done)
                begin
                    bit_cnt      <= '0;
                    bus_data_low <= 1'b0;
                    case (state)
                        ST_CTRL:
                            state <= ST_ADDR;
                        ST_ADDR:
                            state <= ST_DATA;
                        ST_DATA:
                        begin
                            state     <= ST_WAIT_STOP;
                            mem_write <= '{en: 1'b1, block: mem_read.block,
                                           addr: mem_read.addr, data: rx.raw};
                        end
                        default:
                        begin
                            // first read bit goes out on this same fall
                            state        <= ST_RD_OUT;
                            bus_data_low <= ~read_byte[7];
                        end
                    endcase
                end
            end
            else if (state == ST_RD_OUT)
            begin
                if (events.clk_rise)
                    bit_cnt <= bit_cnt + 4'd1;

                if (events.clk_fall)
                begin
                    if (bit_cnt < 4'd8)
                    begin
                        bus_data_low <= ~tx_shift[7];
                    end
                    else
                    begin
                        // master gives the nack
                        bus_data_low <= 1'b0;
                        state        <= ST_WAIT_STOP;
                    end
                end
            end
        end
    end

    // shift registers
    always_ff @(posedge scl)
    begin
        if (receiving && events.clk_rise && bit_cnt < 4'd8)
            rx.raw <= {rx.raw[6:0], events.data};

        if (ack_done && state == ST_RD_CTRL)
            tx_shift <= {read_byte[6:0], 1'b0};
        else if (state == ST_RD_OUT && events.clk_fall && bit_cnt < 4'd8)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

endmodule

//--- design/memory_bank.sv
`include "serial_eeprom_config.svh"

module memory_bank #(
    parameter int bank_index = 0
) (
    input  logic                          scl,
    input  serial_eeprom_pkg::mem_write_t mem_write,
    input  serial_eeprom_pkg::mem_read_t  mem_read,
    output logic [7:0]                    rd_data
);

    logic [7:0] mem [`SE_BANK_DEPTH];
    logic       hit;

    // every bank sees the strobe, only the addressed one takes it
    assign hit = mem_write.en && (mem_write.block == 3'(bank_index));

    always_ff @(posedge scl)
    begin
        if (hit)
            mem[mem_write.addr] <= mem_write.data;
    end

    // read word follows the read address every cycle
    always_ff @(posedge scl)
    begin
        rd_data <= mem[mem_read.addr];
    end

endmodule

//--- design/read_select.sv
`include "serial_eeprom_config.svh"

module read_select (
    input  logic                               scl,
    input  logic                               rst_n,
    input  logic [`SE_BANK_COUNT-1:0][7:0]     bank_data,
    input  serial_eeprom_pkg::mem_read_t       mem_read,
    output logic [7:0]                         read_byte
);

    logic [7:0] picked;

    // block field names the bank
    assign picked = bank_data[mem_read.block];

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            read_byte <= '0;
        end
        else
        begin
            read_byte <= picked;
        end
    end

endmodule

//--- design/serial_eeprom_top.sv
`include "serial_eeprom_config.svh"

module serial_eeprom_top (
    input  logic scl,
    input  logic rst_n,
    input  logic bus_clk,
    input  logic bus_data,
    output logic bus_data_low
);

    import serial_eeprom_pkg::*;

    bus_events_t                    events;
    mem_write_t                     mem_write;
    mem_read_t                      mem_read;
    logic [`SE_BANK_COUNT-1:0][7:0] bank_data;
    logic [7:0]                     read_byte;

    bus_condition_detect u_detect (
        .scl      (scl),
        .rst_n    (rst_n),
        .bus_clk  (bus_clk),
        .bus_data (bus_data),
        .events   (events)
    );

    transfer_sequencer u_seq (
        .scl          (scl),
        .rst_n        (rst_n),
        .events       (events),
        .read_byte    (read_byte),
        .mem_write    (mem_write),
        .mem_read     (mem_read),
        .bus_data_low (bus_data_low)
    );

    // one bank per block
    for (genvar i = 0; i < `SE_BANK_COUNT; i++)
    begin : g_bank
        memory_bank #(
            .bank_index (i)
        ) u_bank (
            .scl       (scl),
            .mem_write (mem_write),
            .mem_read  (mem_read),
            .rd_data   (bank_data[i])
        );
    end

    read_select u_rsel (
        .scl       (scl),
        .rst_n     (rst_n),
        .bank_data (bank_data),
        .mem_read  (mem_read),
        .read_byte (read_byte)
    );

endmodule

//--- verif/serial_eeprom_tb.sv
`include "serial_eeprom_config.svh"

module serial_eeprom_tb;

    logic        scl = 1'b0;
    logic        rst_n;
    logic        bus_clk;
    logic        master_data;
    logic        bus_data;
    logic        bus_data_low;

    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          pass_cnt;
    int          fail_cnt;
    logic        rec_ok;
    string       test_name;

    logic [7:0]  rec_op [$];
    logic [7:0]  rec_blk [$];
    logic [7:0]  rec_addr [$];
    logic [7:0]  rec_data [$];
    logic [7:0]  rec_exp [$];

    // the slave can only pull the wired data line low
    assign bus_data = master_data & ~bus_data_low;

    serial_eeprom_top uut (
        .scl          (scl),
        .rst_n        (rst_n),
        .bus_clk      (bus_clk),
        .bus_data     (bus_data),
        .bus_data_low (bus_data_low)
    );

    always #10 scl = ~scl;

    always @(posedge scl)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("timeout: run did not end within %0d clock cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] make_ctrl(input logic [7:0] blk, input logic rw);
        return {`SE_DEVICE_CODE, blk[2:0], rw};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge scl);
    endtask

    // one bus clock phase of eight cycles plus a little jitter
    task automatic wait_phase();
        logic [31:0] r;
        r = next_rand();
        wait_cycles(8 + int'(r[17:16]));
    endtask

    // data set in the low phase and sampled at the end of the high phase
    task automatic clock_bit(input logic b, output logic seen);
        wait_cycles(2);
        master_data = b;
        wait_phase();
        bus_clk = 1'b1;
        wait_phase();
        seen = bus_data;
        bus_clk = 1'b0;
    endtask

    // also serves as repeated start when the clock is low
    task automatic send_start();
        wait_cycles(2);
        master_data = 1'b1;
        wait_phase();
        bus_clk = 1'b1;
        wait_phase();
        master_data = 1'b0;
        wait_phase();
        bus_clk = 1'b0;
    endtask

    task automatic send_stop();
        wait_cycles(2);
        master_data = 1'b0;
        wait_phase();
        bus_clk = 1'b1;
        wait_phase();
        master_data = 1'b1;
        wait_phase();
        if (bus_data_low !== 1'b0)
        begin
            $display("%s: slave still pulls the data line low after stop", test_name);
            rec_ok = 1'b0;
        end
    endtask

    task automatic send_byte(input logic [7:0] b, output logic acked);
        logic       seen;
        logic [7:0] sh;
        sh = b;
        repeat (8)
        begin
            clock_bit(sh[7], seen);
            sh = {sh[6:0], 1'b0};
        end
        // ninth bit released for the slave
        clock_bit(1'b1, seen);
        acked = ~seen;
    endtask

    task automatic recv_byte(output logic [7:0] b);
        logic       seen;
        logic [7:0] sh;
        sh = 8'h00;
        repeat (8)
        begin
            clock_bit(1'b1, seen);
            sh = {sh[6:0], seen};
        end
        // nack ends the read
        clock_bit(1'b1, seen);
        b = sh;
    endtask

    task automatic run_write(input logic [7:0] ctrl, input logic [7:0] addr,
                             input logic [7:0] data, input logic abort,
                             output logic [2:0] acks);
        logic a_ctrl;
        logic a_addr;
        logic a_data;
        send_start();
        send_byte(ctrl, a_ctrl);
        send_byte(addr, a_addr);
        a_data = 1'b0;
        if (!abort)
            send_byte(data, a_data);
        send_stop();
        acks = {a_ctrl, a_addr, a_data};
    endtask

    task automatic run_read(input logic [7:0] blk, input logic [7:0] addr,
                            output logic [7:0] data, output logic [2:0] acks);
        logic a_ctrl;
        logic a_addr;
        logic a_rd;
        send_start();
        send_byte(make_ctrl(blk, 1'b0), a_ctrl);
        send_byte(addr, a_addr);
        send_start();
        send_byte(make_ctrl(blk, 1'b1), a_rd);
        recv_byte(data);
        send_stop();
        acks = {a_ctrl, a_addr, a_rd};
    endtask

    task automatic check_acks(input logic [2:0] exp, input logic [2:0] acks);
        if ((exp & ~acks) != 3'b000)
        begin
            $display("%s: slave gave no acknowledge where one was due (bits %03b)",
                     test_name, exp & ~acks);
            rec_ok = 1'b0;
        end
        if ((acks & ~exp) != 3'b000)
        begin
            $display("ERR %s expected acks %03b actual acks %03b", test_name, exp, acks);
            rec_ok = 1'b0;
        end
    endtask

    initial
    begin
        int         fd;
        int         c;
        int         n;
        int         idx;
        logic [7:0] ch;
        logic [7:0] f_blk;
        logic [7:0] f_addr;
        logic [7:0] f_data;
        logic [7:0] f_exp;
        logic [2:0] acks;
        logic [7:0] got;

        rst_n       = 1'b0;
        bus_clk     = 1'b1;
        master_data = 1'b1;
        lcg_state   = 32'h5a96_7bac;
        pass_cnt    = 0;
        fail_cnt    = 0;
        rec_ok      = 1'b1;
        test_name   = "reset";

        fd = $fopen("verif/serial_eeprom_golden.txt", "r");
        if (fd == 0)
        begin
            $display("golden file verif/serial_eeprom_golden.txt could not be opened");
            fail_cnt++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                c = $fgetc(fd);
                if (c != -1)
                begin
                    ch = 8'(c);
                    if (ch == "#")
                    begin
                        while (c != 10 && c != -1)
                            c = $fgetc(fd);
                    end
                    else if (ch == "W" || ch == "R" || ch == "A" || ch == "X")
                    begin
                        n = $fscanf(fd, " %h %h %h %h", f_blk, f_addr, f_data, f_exp);
                        if (n == 4)
                        begin
                            rec_op.push_back(ch);
                            rec_blk.push_back(f_blk);
                            rec_addr.push_back(f_addr);
                            rec_data.push_back(f_data);
                            rec_exp.push_back(f_exp);
                        end
                        else
                        begin
                            $display("malformed line in golden file after op %c", ch);
                            fail_cnt++;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        if (rec_op.size() == 0)
        begin
            $display("golden file holds no records");
            fail_cnt++;
        end

        // longest transaction is about 40 bus bits
        cycle_limit = rec_op.size() * 40 * 22 * 2 + 16;

        repeat (8) @(negedge scl);
        rst_n = 1'b1;
        @(negedge scl);
        if (bus_data_low !== 1'b0)
        begin
            $display("bus_data_low is not released after reset");
            fail_cnt++;
        end
        else
        begin
            pass_cnt++;
            $display("PASS reset release");
        end

        for (idx = 0; idx < rec_op.size(); idx++)
        begin
            rec_ok = 1'b1;
            test_name = $sformatf("t%0d_%c_b%02h_a%02h", idx, rec_op[idx],
                                  rec_blk[idx], rec_addr[idx]);
            case (rec_op[idx])
                "W":
                begin
                    run_write(make_ctrl(rec_blk[idx], 1'b0), rec_addr[idx],
                              rec_data[idx], 1'b0, acks);
                    check_acks(rec_exp[idx][2:0], acks);
                end
                "A":
                begin
                    run_write(make_ctrl(rec_blk[idx], 1'b0), rec_addr[idx],
                              rec_data[idx], 1'b1, acks);
                    check_acks(rec_exp[idx][2:0], acks);
                end
                "X":
                begin
                    // blk column carries device code and block
                    run_write({rec_blk[idx][6:0], 1'b0}, rec_addr[idx],
                              rec_data[idx], 1'b0, acks);
                    check_acks(rec_exp[idx][2:0], acks);
                end
                default:
                begin
                    run_read(rec_blk[idx], rec_addr[idx], got, acks);
                    if (acks != 3'b111)
                    begin
                        $display("%s: slave did not acknowledge every byte of the read (%03b)",
                                 test_name, acks);
                        rec_ok = 1'b0;
                    end
                    if (got !== rec_exp[idx])
                    begin
                        $display("ERR %s expected %02h actual %02h", test_name,
                                 rec_exp[idx], got);
                        rec_ok = 1'b0;
                    end
                end
            endcase
            if (rec_ok)
            begin
                pass_cnt++;
                $display("PASS %s", test_name);
            end
            else
            begin
                fail_cnt++;
                $display("FAIL %s", test_name);
            end
        end

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- verif/serial_eeprom_golden.txt
# op blk addr data exp: W write, A write stopped after address, exp = acks {ctrl,addr,data}
# X write with blk as 7 bits of device code and block; R random read, exp = byte read back
W 0 10 a5 7
R 0 10 00 a5
W 2 00 5a 7
W 5 ff c3 7
R 2 00 00 5a
R 5 ff 00 c3
W 0 3c 0f 7
W 1 3c 2e 7
W 2 3c 4d 7
W 3 3c 6c 7
W 4 3c 8b 7
W 5 3c aa 7
W 6 3c c9 7
W 7 3c e8 7
R 0 3c 00 0f
R 1 3c 00 2e
R 2 3c 00 4d
R 3 3c 00 6c
R 4 3c 00 8b
R 5 3c 00 aa
R 6 3c 00 c9
R 7 3c 00 e8
X 5b 3c ee 0
R 3 3c 00 6c
X 10 10 77 0
R 0 10 00 a5
A 4 3c 99 6
R 4 3c 00 8b
A 0 10 00 6
R 0 10 00 a5
W 7 80 00 7
R 7 80 00 00

//--- serial_eeprom.f
+incdir+include
design/serial_eeprom_pkg.sv
design/bus_condition_detect.sv
design/transfer_sequencer.sv
design/memory_bank.sv
design/read_select.sv
design/serial_eeprom_top.sv
verif/serial_eeprom_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := serial_eeprom_tb
FILELIST := serial_eeprom.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Done: errors found
PASS_MSG := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
